//--- common/nes_glue_pkg.sv
/*
 * nes glue package
 * word types, host register map, slot phases and button bit positions
 */
package nes_glue_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  btn_t;      // R L D U START SELECT B A, msb first, 1 = pressed
  typedef logic [21:0] mem_addr_t; // 4MB space
  typedef logic [2:0]  ce_t;

  // host register map
  localparam byte_t HOST_ADDR_CONF   = 8'h35;
  localparam byte_t HOST_ADDR_LOADER = 8'h37;
  localparam byte_t HOST_ADDR_BTN1   = 8'h40;
  localparam byte_t HOST_ADDR_BTN2   = 8'h41;

  localparam int CONF_BIT_HOLD = 0; // holds the loader in reset

  // five-phase round, 0 to 4
  localparam ce_t CE_LAST   = 3'd4;
  localparam ce_t MEM_PHASE = 3'd0;
  localparam ce_t NES_PHASE = 3'd4;

  // nes button word positions
  localparam int BTN_R      = 7;
  localparam int BTN_L      = 6;
  localparam int BTN_D      = 5;
  localparam int BTN_U      = 4;
  localparam int BTN_START  = 3;
  localparam int BTN_SELECT = 2;
  localparam int BTN_B      = 1;
  localparam int BTN_A      = 0;

  // dualshock rx byte 0, active low
  localparam int DS_BIT_R      = 5;
  localparam int DS_BIT_L      = 7;
  localparam int DS_BIT_D      = 6;
  localparam int DS_BIT_U      = 4;
  localparam int DS_BIT_START  = 3;
  localparam int DS_BIT_SELECT = 0;

  // dualshock rx byte 1, active low
  localparam int DS_BIT_B        = 6; // X
  localparam int DS_BIT_A        = 5; // O
  localparam int DS_BIT_SQUARE   = 7;
  localparam int DS_BIT_TRIANGLE = 4;

endpackage

//--- common/joy_btn_if.sv
/*
 * joypad button bundle
 * pad and host override buttons of both players, plain levels
 */
`timescale 1ns/100ps

interface joy_btn_if;

  nes_glue_pkg::btn_t pad_btn1;
  nes_glue_pkg::btn_t pad_btn2;
  nes_glue_pkg::btn_t host_btn1;
  nes_glue_pkg::btn_t host_btn2;

  // decoded dualshock buttons
  modport pad (output pad_btn1, output pad_btn2);

  // host register overrides
  modport host (output host_btn1, output host_btn2);

  modport port (
    input pad_btn1,
    input pad_btn2,
    input host_btn1,
    input host_btn2
  );

endinterface

//--- input/autofire.sv
/*
 * autofire
 * square wave of AUTOFIRE_HALF cycles per half period while held
 */
`timescale 1ns/100ps

module autofire #(
  parameter int AUTOFIRE_HALF = 1_000_000
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic held,
  output logic fire
);

  localparam int CNT_W = (AUTOFIRE_HALF > 1) ? $clog2(AUTOFIRE_HALF) : 1;

  logic [CNT_W-1:0] cnt;
  logic             fire_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn || !held) begin
      // release restarts the wave from low
      cnt    <= '0;
      fire_q <= 1'b0;
    end else if (cnt == CNT_W'(AUTOFIRE_HALF - 1)) begin
      cnt    <= '0;
      fire_q <= ~fire_q; // half period done
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign fire = fire_q & held; // low as soon as released

endmodule

//--- input/pad_decoder.sv
/*
 * dualshock decoder
 * maps the two active-low rx bytes of each pad onto nes button order,
 * square and triangle add autofire on B and A
 */
`timescale 1ns/100ps

module pad_decoder #(
  parameter int AUTOFIRE_HALF = 1_000_000
) (
  input  logic                clk,
  input  logic                sys_resetn,
  input  nes_glue_pkg::byte_t ds1_rx0,
  input  nes_glue_pkg::byte_t ds1_rx1,
  input  nes_glue_pkg::byte_t ds2_rx0,
  input  nes_glue_pkg::byte_t ds2_rx1,
  joy_btn_if.pad              btn
);

  logic fire_b1;
  logic fire_a1;
  logic fire_b2;
  logic fire_a2;

  // same rule for both players
  function automatic nes_glue_pkg::btn_t map_pad(input nes_glue_pkg::byte_t rx0,
                                                 input nes_glue_pkg::byte_t rx1,
                                                 input logic af_b,
                                                 input logic af_a);
    nes_glue_pkg::btn_t b;
    b[nes_glue_pkg::BTN_R]      = ~rx0[nes_glue_pkg::DS_BIT_R];
    b[nes_glue_pkg::BTN_L]      = ~rx0[nes_glue_pkg::DS_BIT_L];
    b[nes_glue_pkg::BTN_D]      = ~rx0[nes_glue_pkg::DS_BIT_D];
    b[nes_glue_pkg::BTN_U]      = ~rx0[nes_glue_pkg::DS_BIT_U];
    b[nes_glue_pkg::BTN_START]  = ~rx0[nes_glue_pkg::DS_BIT_START];
    b[nes_glue_pkg::BTN_SELECT] = ~rx0[nes_glue_pkg::DS_BIT_SELECT];
    b[nes_glue_pkg::BTN_B]      = ~rx1[nes_glue_pkg::DS_BIT_B] | af_b; // X or square fire
    b[nes_glue_pkg::BTN_A]      = ~rx1[nes_glue_pkg::DS_BIT_A] | af_a; // O or triangle fire
    return b;
  endfunction

  autofire #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_af_b1 (
    .clk (clk), .sys_resetn (sys_resetn),
    .held (~ds1_rx1[nes_glue_pkg::DS_BIT_SQUARE]), .fire (fire_b1)
  );

  autofire #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_af_a1 (
    .clk (clk), .sys_resetn (sys_resetn),
    .held (~ds1_rx1[nes_glue_pkg::DS_BIT_TRIANGLE]), .fire (fire_a1)
  );

  autofire #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_af_b2 (
    .clk (clk), .sys_resetn (sys_resetn),
    .held (~ds2_rx1[nes_glue_pkg::DS_BIT_SQUARE]), .fire (fire_b2)
  );

  autofire #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_af_a2 (
    .clk (clk), .sys_resetn (sys_resetn),
    .held (~ds2_rx1[nes_glue_pkg::DS_BIT_TRIANGLE]), .fire (fire_a2)
  );

  assign btn.pad_btn1 = map_pad(ds1_rx0, ds1_rx1, fire_b1, fire_a1);
  assign btn.pad_btn2 = map_pad(ds2_rx0, ds2_rx1, fire_b2, fire_a2);

endmodule

//--- input/joypad_port.sv
/*
 * nes joypad ports
 * two shift registers, loaded on strobe, shifted on falling joypad clock
 */
`timescale 1ns/100ps

module joypad_port (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,
  joy_btn_if.port    btn,
  output logic [1:0] joypad_data
);

  nes_glue_pkg::btn_t merged [2];
  nes_glue_pkg::btn_t bits [2];
  logic [1:0]         last_clock;
  logic [1:0]         clock_fall;

  // host override ORed onto the pad
  assign merged[0] = btn.host_btn1 | btn.pad_btn1;
  assign merged[1] = btn.host_btn2 | btn.pad_btn2;

  assign clock_fall = last_clock & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      last_clock <= '0;
      bits[0]    <= '0;
      bits[1]    <= '0;
    end else begin
      last_clock <= joypad_clock;
      for (int i = 0; i < 2; i++) begin
        if (joypad_strobe)
          bits[i] <= merged[i];
        if (clock_fall[i])
          bits[i] <= {1'b0, bits[i][7:1]}; // shift wins over strobe
      end
    end
  end

  assign joypad_data = {bits[1][0], bits[0][0]};

endmodule

//--- memory/mem_slot_sequencer.sv
/*
 * memory slot sequencer
 * five-phase round: memory runs in phase 0, the nes in phase 4.
 * loader writes bypass the slot, idle slots issue refresh
 */
`timescale 1ns/100ps

module mem_slot_sequencer (
  input  logic                    clk,
  input  logic                    sys_resetn,
  input  logic                    loader_done,
  input  logic                    cpu_read,
  input  logic                    ppu_read,
  input  logic                    nes_write,
  input  nes_glue_pkg::mem_addr_t nes_addr,
  input  nes_glue_pkg::byte_t     nes_wdata,
  input  logic                    loader_write,
  input  logic                    loader_refresh,
  input  nes_glue_pkg::mem_addr_t loader_addr,
  input  nes_glue_pkg::byte_t     loader_wdata,
  output logic                    reset_nes,
  output logic                    run_nes,
  output logic                    mem_read_a,
  output logic                    mem_read_b,
  output logic                    mem_write,
  output logic                    mem_refresh,
  output nes_glue_pkg::mem_addr_t mem_addr,
  output nes_glue_pkg::byte_t     mem_wdata
);

  nes_glue_pkg::ce_t phase;
  logic              run_mem;
  logic              nes_idle;

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      phase <= nes_glue_pkg::MEM_PHASE;
    else if (phase == nes_glue_pkg::CE_LAST)
      phase <= nes_glue_pkg::MEM_PHASE; // wrap after the nes slot
    else
      phase <= phase + 3'd1;
  end

  // nes held in reset until the game is loaded
  assign reset_nes = ~loader_done;

  assign run_mem = (phase == nes_glue_pkg::MEM_PHASE) && !reset_nes;
  assign run_nes = (phase == nes_glue_pkg::NES_PHASE) && !reset_nes;

  // nes requests only reach memory in its slot
  assign mem_read_a = cpu_read && run_mem;
  assign mem_read_b = ppu_read && run_mem;
  assign mem_write  = (nes_write && run_mem) || loader_write;

  assign nes_idle = ~cpu_read & ~ppu_read & ~nes_write & ~loader_write;

  // unused slot or loader asking for it
  assign mem_refresh = (nes_idle && run_mem) || (loader_refresh && !loader_write);

  // loader has priority on the bus
  assign mem_addr  = loader_write ? loader_addr : nes_addr;
  assign mem_wdata = loader_write ? loader_wdata : nes_wdata;

endmodule

//--- design/host_regs.sv
/*
 * host register port
 * decodes host writes into loader config and button overrides,
 * and forwards loader address writes as a byte stream
 */
`timescale 1ns/100ps

module host_regs (
  input  logic                clk,
  input  logic                sys_resetn,
  input  nes_glue_pkg::byte_t host_addr,
  input  nes_glue_pkg::byte_t host_data,
  input  logic                host_write,
  output nes_glue_pkg::byte_t loader_byte,
  output logic                loader_strobe,
  output logic                loader_reset,
  joy_btn_if.host             btn
);

  logic               wr_conf;
  logic               wr_btn1;
  logic               wr_btn2;
  logic               loader_hold; // only config bit in use
  nes_glue_pkg::btn_t btn1_q;
  nes_glue_pkg::btn_t btn2_q;

  assign wr_conf = host_write && (host_addr == nes_glue_pkg::HOST_ADDR_CONF);
  assign wr_btn1 = host_write && (host_addr == nes_glue_pkg::HOST_ADDR_BTN1);
  assign wr_btn2 = host_write && (host_addr == nes_glue_pkg::HOST_ADDR_BTN2);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      loader_hold <= 1'b0;
      btn1_q      <= '0;
      btn2_q      <= '0;
    end else begin
      if (wr_conf)
        loader_hold <= host_data[nes_glue_pkg::CONF_BIT_HOLD];
      if (wr_btn1)
        btn1_q <= host_data;
      if (wr_btn2)
        btn2_q <= host_data;
    end
  end

  // game bytes go straight through, same cycle
  assign loader_strobe = host_write && (host_addr == nes_glue_pkg::HOST_ADDR_LOADER);
  assign loader_byte   = host_data;

  assign loader_reset = ~sys_resetn | loader_hold;

  assign btn.host_btn1 = btn1_q;
  assign btn.host_btn2 = btn2_q;

endmodule

//--- design/nes_glue_top.sv
/*
 * nes glue top level
 * host registers, dualshock decode, joypad ports and memory slot sequencer
 */
`timescale 1ns/100ps

module nes_glue_top #(
  parameter int AUTOFIRE_HALF = 1_000_000
) (
  input  logic                    clk,
  input  logic                    sys_resetn,
  // host port
  input  nes_glue_pkg::byte_t     host_addr,
  input  nes_glue_pkg::byte_t     host_data,
  input  logic                    host_write,
  // dualshock receive bytes
  input  nes_glue_pkg::byte_t     ds1_rx0,
  input  nes_glue_pkg::byte_t     ds1_rx1,
  input  nes_glue_pkg::byte_t     ds2_rx0,
  input  nes_glue_pkg::byte_t     ds2_rx1,
  // loader
  output nes_glue_pkg::byte_t     loader_byte,
  output logic                    loader_strobe,
  output logic                    loader_reset,
  input  logic                    loader_done,
  input  nes_glue_pkg::mem_addr_t loader_addr,
  input  nes_glue_pkg::byte_t     loader_wdata,
  input  logic                    loader_write,
  input  logic                    loader_refresh,
  // nes core
  input  logic                    joypad_strobe,
  input  logic [1:0]              joypad_clock,
  output logic [1:0]              joypad_data,
  input  logic                    cpu_read,
  input  logic                    ppu_read,
  input  logic                    nes_write,
  input  nes_glue_pkg::mem_addr_t nes_addr,
  input  nes_glue_pkg::byte_t     nes_wdata,
  output logic                    reset_nes,
  output logic                    run_nes,
  // memory controller
  output logic                    mem_read_a,
  output logic                    mem_read_b,
  output logic                    mem_write,
  output logic                    mem_refresh,
  output nes_glue_pkg::mem_addr_t mem_addr,
  output nes_glue_pkg::byte_t     mem_wdata
);

  joy_btn_if u_btn_if ();

  host_regs u_host_regs (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .host_addr     (host_addr),
    .host_data     (host_data),
    .host_write    (host_write),
    .loader_byte   (loader_byte),
    .loader_strobe (loader_strobe),
    .loader_reset  (loader_reset),
    .btn           (u_btn_if.host)
  );

  pad_decoder #(
    .AUTOFIRE_HALF (AUTOFIRE_HALF)
  ) u_pad_decoder (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .ds1_rx0    (ds1_rx0),
    .ds1_rx1    (ds1_rx1),
    .ds2_rx0    (ds2_rx0),
    .ds2_rx1    (ds2_rx1),
    .btn        (u_btn_if.pad)
  );

  joypad_port u_joypad_port (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .btn           (u_btn_if.port),
    .joypad_data   (joypad_data)
  );

  mem_slot_sequencer u_mem_slot_sequencer (
    .clk            (clk),
    .sys_resetn     (sys_resetn),
    .loader_done    (loader_done),
    .cpu_read       (cpu_read),
    .ppu_read       (ppu_read),
    .nes_write      (nes_write),
    .nes_addr       (nes_addr),
    .nes_wdata      (nes_wdata),
    .loader_write   (loader_write),
    .loader_refresh (loader_refresh),
    .loader_addr    (loader_addr),
    .loader_wdata   (loader_wdata),
    .reset_nes      (reset_nes),
    .run_nes        (run_nes),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata)
  );

endmodule

//--- dv/nes_glue_sva.sv
/*
 * nes glue checker
 * reference models of the host, pad, joypad and slot rules,
 * with concurrent assertions, bound into nes_glue_top
 */
`timescale 1ns/100ps

module nes_glue_sva #(
  parameter int AUTOFIRE_HALF = 8
) (
  input logic        clk,
  input logic        sys_resetn,
  input logic [7:0]  host_addr,
  input logic [7:0]  host_data,
  input logic        host_write,
  input logic [7:0]  loader_byte,
  input logic        loader_strobe,
  input logic        loader_reset,
  input logic [7:0]  ds1_rx0,
  input logic [7:0]  ds1_rx1,
  input logic [7:0]  ds2_rx0,
  input logic [7:0]  ds2_rx1,
  input logic        joypad_strobe,
  input logic [1:0]  joypad_clock,
  input logic [1:0]  joypad_data,
  input logic        loader_done,
  input logic        loader_write,
  input logic        loader_refresh,
  input logic [21:0] loader_addr,
  input logic [7:0]  loader_wdata,
  input logic        cpu_read,
  input logic        ppu_read,
  input logic        nes_write,
  input logic [21:0] nes_addr,
  input logic [7:0]  nes_wdata,
  input logic        reset_nes,
  input logic        run_nes,
  input logic        mem_read_a,
  input logic        mem_read_b,
  input logic        mem_write,
  input logic        mem_refresh,
  input logic [21:0] mem_addr,
  input logic [7:0]  mem_wdata
);

  logic        hold_m;        // config bit 0
  logic [7:0]  ovr_m [2];
  logic [7:0]  word_m [2];    // last latched word per port
  logic [3:0]  shifts_m [2];  // falling edges since strobe, stops at 8
  logic [1:0]  jclk_q;
  logic [2:0]  ph_m;
  int          held_n [4];    // cycles held, order b1 a1 b2 a2
  logic [3:0]  held;
  logic [3:0]  fire_m;
  logic [7:0]  exp_word [2];
  logic [1:0]  exp_data;
  logic        loader_hit;
  logic        slot_m;
  logic        exp_run_nes;
  logic [1:0]  exp_reads;
  logic        exp_refresh;
  logic [30:0] exp_bus;       // write, addr, wdata
  int          fail_loader = 0;
  int          fail_reset = 0;
  int          fail_joypad = 0;
  int          fail_run = 0;
  int          fail_read = 0;
  int          fail_refresh = 0;
  int          fail_bus = 0;
  int          fail_total;

  // R L D U START SELECT B A from the active-low pad bytes
  function automatic logic [7:0] nes_word(input logic [7:0] b0, input logic [7:0] b1,
                                          input logic fb, input logic fa);
    logic [7:0] p0;
    logic [7:0] p1;
    p0 = ~b0;
    p1 = ~b1;
    return {p0[5], p0[7], p0[6], p0[4], p0[3], p0[0], p1[6] | fb, p1[5] | fa};
  endfunction

  assign held = {~ds2_rx1[4], ~ds2_rx1[7], ~ds1_rx1[4], ~ds1_rx1[7]};

  always_comb begin
    for (int k = 0; k < 4; k++)
      fire_m[k] = held[k] && ((held_n[k] / AUTOFIRE_HALF) % 2 == 1);
    for (int i = 0; i < 2; i++)
      exp_data[i] = shifts_m[i][3] ? 1'b0 : word_m[i][shifts_m[i][2:0]];
  end

  assign exp_word[0] = ovr_m[0] | nes_word(ds1_rx0, ds1_rx1, fire_m[0], fire_m[1]);
  assign exp_word[1] = ovr_m[1] | nes_word(ds2_rx0, ds2_rx1, fire_m[2], fire_m[3]);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      hold_m <= 1'b0;
      jclk_q <= 2'b00;
      ph_m   <= 3'd0;
      for (int i = 0; i < 2; i++) begin
        ovr_m[i]    <= 8'h00;
        word_m[i]   <= 8'h00;
        shifts_m[i] <= 4'd0;
      end
      for (int k = 0; k < 4; k++)
        held_n[k] <= 0;
    end else begin
      jclk_q <= joypad_clock;
      ph_m   <= (ph_m == 3'd4) ? 3'd0 : ph_m + 3'd1;
      if (host_write && host_addr == 8'h35)
        hold_m <= host_data[0];
      if (host_write && host_addr == 8'h40)
        ovr_m[0] <= host_data;
      if (host_write && host_addr == 8'h41)
        ovr_m[1] <= host_data;
      for (int i = 0; i < 2; i++) begin
        if (joypad_strobe) begin
          word_m[i]   <= exp_word[i];
          shifts_m[i] <= 4'd0;
        end else if (jclk_q[i] && !joypad_clock[i] && !shifts_m[i][3]) begin
          shifts_m[i] <= shifts_m[i] + 4'd1;
        end
      end
      for (int k = 0; k < 4; k++)
        held_n[k] <= held[k] ? held_n[k] + 1 : 0;
    end
  end

  assign loader_hit  = host_write && host_addr == 8'h37;
  assign slot_m      = loader_done && ph_m == 3'd0; // memory slot
  assign exp_run_nes = loader_done && ph_m == 3'd4;
  assign exp_reads   = {ppu_read && slot_m, cpu_read && slot_m};
  assign exp_refresh = (slot_m && !(cpu_read || ppu_read || nes_write || loader_write))
                       || (loader_refresh && !loader_write);
  assign exp_bus     = {loader_write || (nes_write && slot_m),
                        loader_write ? loader_addr : nes_addr,
                        loader_write ? loader_wdata : nes_wdata};

  assign fail_total = fail_loader + fail_reset + fail_joypad + fail_run + fail_read
                      + fail_refresh + fail_bus;

  a_loader: assert property (@(posedge clk) disable iff (!sys_resetn)
    loader_strobe == loader_hit && (!loader_hit || loader_byte == host_data))
  else begin
    fail_loader++;
    $error("MISMATCH t=%0t loader_strobe/loader_byte exp=%b/%h got=%b/%h", $time,
           $sampled(loader_hit), $sampled(host_data), $sampled(loader_strobe),
           $sampled(loader_byte));
  end

  a_loader_reset: assert property (@(posedge clk) loader_reset == (!sys_resetn || hold_m))
  else begin
    fail_reset++;
    $error("MISMATCH t=%0t loader_reset exp=%b got=%b", $time,
           $sampled(!sys_resetn || hold_m), $sampled(loader_reset));
  end

  a_joypad: assert property (@(posedge clk) disable iff (!sys_resetn)
    joypad_data == exp_data)
  else begin
    fail_joypad++;
    $error("MISMATCH t=%0t joypad_data exp=%b got=%b", $time,
           $sampled(exp_data), $sampled(joypad_data));
  end

  a_run_nes: assert property (@(posedge clk) disable iff (!sys_resetn)
    {reset_nes, run_nes} == {!loader_done, exp_run_nes})
  else begin
    fail_run++;
    $error("MISMATCH t=%0t reset_nes/run_nes exp=%b%b got=%b%b", $time,
           $sampled(!loader_done), $sampled(exp_run_nes), $sampled(reset_nes),
           $sampled(run_nes));
  end

  a_mem_read: assert property (@(posedge clk) disable iff (!sys_resetn)
    {mem_read_b, mem_read_a} == exp_reads)
  else begin
    fail_read++;
    $error("MISMATCH t=%0t mem_read_b/mem_read_a exp=%b got=%b%b", $time,
           $sampled(exp_reads), $sampled(mem_read_b), $sampled(mem_read_a));
  end

  a_mem_refresh: assert property (@(posedge clk) disable iff (!sys_resetn)
    mem_refresh == exp_refresh)
  else begin
    fail_refresh++;
    $error("MISMATCH t=%0t mem_refresh exp=%b got=%b", $time,
           $sampled(exp_refresh), $sampled(mem_refresh));
  end

  a_mem_bus: assert property (@(posedge clk) disable iff (!sys_resetn)
    {mem_write, mem_addr, mem_wdata} == exp_bus)
  else begin
    fail_bus++;
    $error("MISMATCH t=%0t mem_write/mem_addr/mem_wdata exp=%h got=%h", $time,
           $sampled(exp_bus), $sampled({mem_write, mem_addr, mem_wdata}));
  end

endmodule

bind nes_glue_top nes_glue_sva #(
  .AUTOFIRE_HALF (AUTOFIRE_HALF)
) u_sva (.*);

//--- dv/tb_nes_glue.sv
/*
 * nes glue testbench
 * drives host writes, dualshock bytes, joypad and memory requests,
 * the bound checker compares every cycle
 */
`timescale 1ns/100ps

module tb_nes_glue;

  localparam int AF_HALF     = 8;
  localparam int LEN_RESET   = 4;
  localparam int LEN_LOADER  = 20;
  localparam int LEN_OVR     = 4 * 24;
  localparam int LEN_MAP     = 4 * 24;
  localparam int LEN_AF      = 3 * (5 * AF_HALF + 2) + 8;
  localparam int LEN_SLOT    = 90;
  localparam int LEN_PRIO    = 40;
  localparam int CYCLE_LIMIT = 2 * (LEN_RESET + LEN_LOADER + LEN_OVR + LEN_MAP + LEN_AF
                                    + LEN_SLOT + LEN_PRIO);

  logic                    clk;
  logic                    sys_resetn;
  nes_glue_pkg::byte_t     host_addr;
  nes_glue_pkg::byte_t     host_data;
  logic                    host_write;
  nes_glue_pkg::byte_t     ds1_rx0;
  nes_glue_pkg::byte_t     ds1_rx1;
  nes_glue_pkg::byte_t     ds2_rx0;
  nes_glue_pkg::byte_t     ds2_rx1;
  nes_glue_pkg::byte_t     loader_byte;
  logic                    loader_strobe;
  logic                    loader_reset;
  logic                    loader_done;
  nes_glue_pkg::mem_addr_t loader_addr;
  nes_glue_pkg::byte_t     loader_wdata;
  logic                    loader_write;
  logic                    loader_refresh;
  logic                    joypad_strobe;
  logic [1:0]              joypad_clock;
  logic [1:0]              joypad_data;
  logic                    cpu_read;
  logic                    ppu_read;
  logic                    nes_write;
  nes_glue_pkg::mem_addr_t nes_addr;
  nes_glue_pkg::byte_t     nes_wdata;
  logic                    reset_nes;
  logic                    run_nes;
  logic                    mem_read_a;
  logic                    mem_read_b;
  logic                    mem_write;
  logic                    mem_refresh;
  nes_glue_pkg::mem_addr_t mem_addr;
  nes_glue_pkg::byte_t     mem_wdata;

  logic [15:0] lfsr = 16'd52040;
  int          cycles = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;
  int          fails_seen = 0; // checker failures already charged to a test

  nes_glue_top #(
    .AUTOFIRE_HALF (AF_HALF)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  initial begin
    wait (cycles >= CYCLE_LIMIT);
    $display("timeout after %0d cycles, the tests did not finish", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], rand_bit()};
    return v;
  endfunction

  function automatic nes_glue_pkg::byte_t rand_byte();
    return 8'(rand_bits(8));
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic host_wr(input nes_glue_pkg::byte_t addr, input nes_glue_pkg::byte_t data);
    host_addr  = addr;
    host_data  = data;
    host_write = 1'b1;
    next_cycle();
    host_write = 1'b0;
  endtask

  // strobe both ports, then give them falling clock edges
  task automatic read_joypads(input int edges);
    joypad_strobe = 1'b1;
    joypad_clock  = 2'b11;
    next_cycle();
    joypad_strobe = 1'b0;
    repeat (edges) begin
      joypad_clock = 2'b00;
      next_cycle();
      joypad_clock = 2'b11;
      next_cycle();
    end
  endtask

  task automatic random_requests(input int n, input logic with_loader);
    repeat (n) begin
      cpu_read       = rand_bit() & rand_bit(); // sparse so idle slots remain
      ppu_read       = rand_bit() & rand_bit();
      nes_write      = rand_bit() & rand_bit();
      nes_addr       = 22'(rand_bits(22));
      nes_wdata      = rand_byte();
      loader_refresh = rand_bit() & rand_bit();
      loader_write   = with_loader & rand_bit();
      loader_addr    = 22'(rand_bits(22));
      loader_wdata   = rand_byte();
      next_cycle();
    end
  endtask

  task automatic end_test(input string name);
    int fails_now;
    next_cycle(); // let the last inputs be checked
    fails_now = u_dut.u_sva.fail_total;
    if (fails_now == fails_seen) begin
      tests_pass++;
      $display("test %s: pass", name);
    end else begin
      tests_fail++;
      $display("test %s: fail, %0d assertion failures", name, fails_now - fails_seen);
    end
    fails_seen = fails_now;
  endtask

  initial begin
    sys_resetn     = 1'b0;
    host_addr      = 8'h00;
    host_data      = 8'h00;
    host_write     = 1'b0;
    ds1_rx0        = 8'hFF; // all released
    ds1_rx1        = 8'hFF;
    ds2_rx0        = 8'hFF;
    ds2_rx1        = 8'hFF;
    loader_done    = 1'b0;
    loader_addr    = '0;
    loader_wdata   = 8'h00;
    loader_write   = 1'b0;
    loader_refresh = 1'b0;
    joypad_strobe  = 1'b0;
    joypad_clock   = 2'b00;
    cpu_read       = 1'b0;
    ppu_read       = 1'b0;
    nes_write      = 1'b0;
    nes_addr       = '0;
    nes_wdata      = 8'h00;
    repeat (LEN_RESET) @(posedge clk);
    #2;
    sys_resetn = 1'b1;

    for (int i = 0; i < 12; i++)
      host_wr((i % 4 == 3) ? nes_glue_pkg::HOST_ADDR_CONF : nes_glue_pkg::HOST_ADDR_LOADER,
              rand_byte());
    host_wr(nes_glue_pkg::HOST_ADDR_CONF, 8'h01);
    host_wr(nes_glue_pkg::HOST_ADDR_CONF, 8'h00);
    end_test("loader stream and reset");

    for (int r = 0; r < 4; r++) begin
      host_wr(nes_glue_pkg::HOST_ADDR_BTN1, rand_byte());
      host_wr(nes_glue_pkg::HOST_ADDR_BTN2, rand_byte());
      read_joypads(9);
    end
    end_test("host overrides");

    for (int r = 0; r < 4; r++) begin
      ds1_rx0 = rand_byte();
      ds1_rx1 = rand_byte() | 8'h90; // square and triangle up
      ds2_rx0 = rand_byte();
      ds2_rx1 = rand_byte() | 8'h90;
      host_wr(nes_glue_pkg::HOST_ADDR_BTN1, rand_byte() & rand_byte());
      host_wr(nes_glue_pkg::HOST_ADDR_BTN2, rand_byte() & rand_byte());
      read_joypads(9);
    end
    end_test("dualshock mapping");

    ds1_rx0 = 8'hFF;
    ds2_rx0 = 8'hFF;
    ds1_rx1 = 8'h6F; // square and triangle held on both pads
    ds2_rx1 = 8'h6F;
    host_wr(nes_glue_pkg::HOST_ADDR_BTN1, 8'h00);
    host_wr(nes_glue_pkg::HOST_ADDR_BTN2, 8'h00);
    repeat (3 * AF_HALF) read_joypads(1);
    ds1_rx1 = 8'hFF;
    ds2_rx1 = 8'hFF;
    repeat (2) read_joypads(1);
    ds1_rx1 = 8'h6F;
    ds2_rx1 = 8'h6F;
    repeat (2 * AF_HALF) read_joypads(1);
    ds1_rx1 = 8'hFF;
    ds2_rx1 = 8'hFF;
    end_test("autofire");

    random_requests(20, 1'b0); // nes still in reset
    loader_done = 1'b1;
    random_requests(60, 1'b0);
    end_test("slot gating");

    random_requests(30, 1'b1);
    loader_write = 1'b0;
    end_test("loader priority");

    $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- compile.f
common/nes_glue_pkg.sv
common/joy_btn_if.sv
input/autofire.sv
input/pad_decoder.sv
input/joypad_port.sv
memory/mem_slot_sequencer.sv
design/host_regs.sv
design/nes_glue_top.sv
dv/nes_glue_sva.sv
dv/tb_nes_glue.sv

//--- Makefile
# Verilator build, run, lint and clean for the nes glue project

VERILATOR ?= verilator
TOP       ?= tb_nes_glue
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timing --assert --timescale 1ns/100ps
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation FAILED" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
